// File: source/axil_pkg.sv
`default_nettype none

package axil_pkg;

   // Register bus widths
   localparam int ADDR_W = 8;
   localparam int DATA_W = 32;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [1:0]        resp_t;

   // Every access completes without error
   localparam resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// File: source/uart_pkg.sv
`default_nettype none

package uart_pkg;

   typedef logic [7:0] byte_t;

   ////////////////////////////////////////////////////////////////////////////
   // Register map, word addresses
   ////////////////////////////////////////////////////////////////////////////
   localparam logic [7:0] A_STATUS = 8'h00;
   localparam logic [7:0] A_INTENA = 8'h04;
   localparam logic [7:0] A_TXD    = 8'h08;
   localparam logic [7:0] A_RXD    = 8'h0C;

   // STATUS bits
   localparam int ST_RX_EMPTY = 0;
   localparam int ST_TX_FULL  = 8;
   localparam int ST_TX_EMPTY = 10;

   // INTENA bits
   localparam int IE_RX = 0;
   localparam int IE_TX = 1;

   ////////////////////////////////////////////////////////////////////////////
   // Serial framing
   ////////////////////////////////////////////////////////////////////////////
   localparam int SAMPLES_PER_BIT = 4;
   localparam int DATA_BITS       = 8;

endpackage

`default_nettype wire

// File: source/axil_slave.sv
`default_nettype none

module axil_slave
   import axil_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  RST_N,
   input  wire addr_t awaddr,
   input  wire logic  awvalid,
   output logic       awready,
   input  wire data_t wdata,
   input  wire logic  wvalid,
   output logic       wready,
   output logic       bvalid,
   input  wire logic  bready,
   output resp_t      bresp,
   input  wire addr_t araddr,
   input  wire logic  arvalid,
   output logic       arready,
   output logic       rvalid,
   input  wire logic  rready,
   output data_t      rdata,
   output resp_t      rresp,
   output addr_t      reg_addr,
   output logic       reg_wr,
   output data_t      reg_wdata,
   output logic       reg_rd,
   input  wire data_t reg_rdata
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_WDATA,
      S_WACC,
      S_WRESP,
      S_RACC,
      S_RRESP
   } state_t;

   state_t state;
   addr_t  addr_q;
   data_t  wdata_q;

   always_ff @(posedge clk or negedge RST_N) begin
      if (!RST_N) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE: begin
               // Write wins when both address channels are valid
               if (awvalid) begin
                  state <= S_WDATA;
               end else if (arvalid) begin
                  state <= S_RACC;
               end
            end
            S_WDATA: begin
               if (wvalid) begin
                  state <= S_WACC;
               end
            end
            S_WACC:  state <= S_WRESP;
            S_WRESP: begin
               if (bready) begin
                  state <= S_IDLE;
               end
            end
            S_RACC:  state <= S_RRESP;
            S_RRESP: begin
               if (rready) begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_IDLE) begin
         if (awvalid) begin
            addr_q <= awaddr;
         end else if (arvalid) begin
            addr_q <= araddr;
         end
      end
      if (wready && wvalid) begin
         wdata_q <= wdata;
      end
   end

   assign awready = (state == S_IDLE);
   assign arready = (state == S_IDLE) && !awvalid;
   assign wready  = (state == S_WDATA);
   assign bvalid  = (state == S_WRESP);
   assign rvalid  = (state == S_RRESP);
   assign bresp   = RESP_OKAY;
   assign rresp   = RESP_OKAY;

   // Read data held by the register block until the next strobe
   assign rdata = reg_rdata;

   // One strobe per transaction
   assign reg_addr  = addr_q;
   assign reg_wdata = wdata_q;
   assign reg_wr    = (state == S_WACC);
   assign reg_rd    = (state == S_RACC);

endmodule

`default_nettype wire

// File: source/uart_ctl.sv
`default_nettype none

module uart_ctl
   import axil_pkg::*;
   import uart_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  RST_N,
   input  wire addr_t reg_addr,
   input  wire logic  reg_wr,
   input  wire data_t reg_wdata,
   input  wire logic  reg_rd,
   output data_t      reg_rdata,
   output logic       tx_push,
   output byte_t      tx_byte,
   input  wire logic  tx_full,
   input  wire logic  tx_fifo_empty,
   input  wire logic  tx_busy,
   output logic       rx_pop,
   input  wire byte_t rx_front,
   input  wire logic  rx_empty,
   output logic       interrupt
);

   addr_t word_addr;
   data_t status;
   logic  ie_rx;
   logic  ie_tx;

   // Low address bits ignored
   assign word_addr = {reg_addr[7:2], 2'b00};

   ////////////////////////////////////////////////////////////////////////////
   // Write side
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge RST_N) begin
      if (!RST_N) begin
         ie_rx <= 1'b0;
         ie_tx <= 1'b0;
      end else if (reg_wr && (word_addr == A_INTENA)) begin
         ie_rx <= reg_wdata[IE_RX];
         ie_tx <= reg_wdata[IE_TX];
      end
   end

   // Full FIFO drops the byte
   assign tx_push = reg_wr && (word_addr == A_TXD) && !tx_full;
   assign tx_byte = reg_wdata[7:0];

   ////////////////////////////////////////////////////////////////////////////
   // Read side
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      status = '0;
      status[ST_RX_EMPTY] = rx_empty;
      status[ST_TX_FULL]  = tx_full;
      // Empty only once the last frame has left the wire
      status[ST_TX_EMPTY] = tx_fifo_empty && !tx_busy;
   end

   always_ff @(posedge clk) begin
      if (reg_rd) begin
         case (word_addr)
            A_STATUS: reg_rdata <= status;
            A_INTENA: reg_rdata <= data_t'({ie_tx, ie_rx});
            A_RXD:    reg_rdata <= rx_empty ? '0 : data_t'(rx_front);
            default:  reg_rdata <= '0;
         endcase
      end
   end

   // Front byte is captured in the same cycle it is popped
   assign rx_pop = reg_rd && (word_addr == A_RXD) && !rx_empty;

   assign interrupt = (ie_tx && tx_full) || (ie_rx && rx_empty);

endmodule

`default_nettype wire

// File: source/byte_fifo.sv
`default_nettype none

module byte_fifo
   import uart_pkg::*;
#(
   parameter int FIFO_AW = 4
)
(
   input  wire logic  clk,
   input  wire logic  RST_N,
   input  wire logic  push,
   input  wire byte_t push_data,
   output logic       full,
   input  wire logic  pop,
   output byte_t      pop_data,
   output logic       empty
);

   localparam int DEPTH = 2 ** FIFO_AW;

   byte_t              mem [DEPTH];
   logic [FIFO_AW:0]   wr_ptr;
   logic [FIFO_AW:0]   rd_ptr;
   logic               do_push;
   logic               do_pop;

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   // Extra wrap bit tells full from empty
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                  (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

   always_ff @(posedge clk or negedge RST_N) begin
      if (!RST_N) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr[FIFO_AW-1:0]] <= push_data;
      end
   end

   // Show-ahead read
   assign pop_data = mem[rd_ptr[FIFO_AW-1:0]];

endmodule

`default_nettype wire

// File: source/baud_tick.sv
`default_nettype none

module baud_tick #(
   parameter int CLKS_PER_TICK = 4
)
(
   input  wire logic clk,
   input  wire logic RST_N,
   output logic      tick
);

   localparam int CW = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;

   logic [CW-1:0] cnt;

   always_ff @(posedge clk or negedge RST_N) begin
      if (!RST_N) begin
         cnt  <= '0;
         tick <= 1'b0;
      end else if (cnt == CW'(CLKS_PER_TICK - 1)) begin
         cnt  <= '0;
         tick <= 1'b1;
      end else begin
         cnt  <= cnt + 1'b1;
         tick <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`default_nettype none

module uart_tx
   import uart_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  RST_N,
   input  wire logic  tick,
   input  wire logic  fifo_empty,
   input  wire byte_t data,
   output logic       pop,
   output logic       busy,
   output logic       txd
);

   localparam int SW = $clog2(SAMPLES_PER_BIT);
   localparam int BW = $clog2(DATA_BITS);

   typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

   state_t        state;
   logic [SW-1:0] smp;
   logic [BW-1:0] bit_cnt;
   byte_t         shreg;
   logic          bit_end;

   assign bit_end = tick && (smp == SW'(SAMPLES_PER_BIT - 1));

   // Load on a tick so every bit spans whole tick periods
   assign pop  = (state == S_IDLE) && tick && !fifo_empty;
   assign busy = (state != S_IDLE);

   always_ff @(posedge clk or negedge RST_N) begin
      if (!RST_N) begin
         state   <= S_IDLE;
         smp     <= '0;
         bit_cnt <= '0;
         txd     <= 1'b1;
      end else begin
         if (state == S_IDLE) begin
            smp <= '0;
         end else if (tick) begin
            smp <= bit_end ? '0 : smp + 1'b1;
         end
         case (state)
            S_IDLE: begin
               if (pop) begin
                  state <= S_START;
                  txd   <= 1'b0;
               end
            end
            S_START: begin
               if (bit_end) begin
                  state   <= S_DATA;
                  bit_cnt <= '0;
                  txd     <= shreg[0];
               end
            end
            S_DATA: begin
               if (bit_end) begin
                  if (bit_cnt == BW'(DATA_BITS - 1)) begin
                     state <= S_STOP;
                     txd   <= 1'b1;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                     txd     <= shreg[0];
                  end
               end
            end
            S_STOP: begin
               if (bit_end) begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // LSB first
   always_ff @(posedge clk) begin
      if (pop) begin
         shreg <= data;
      end else if (bit_end && (state == S_START || state == S_DATA)) begin
         shreg <= shreg >> 1;
      end
   end

endmodule

`default_nettype wire

// File: source/uart_rx.sv
`default_nettype none

module uart_rx
   import uart_pkg::*;
(
   input  wire logic clk,
   input  wire logic RST_N,
   input  wire logic tick,
   input  wire logic rxd,
   output logic      valid,
   output byte_t     data
);

   localparam int SW = $clog2(SAMPLES_PER_BIT);
   localparam int BW = $clog2(DATA_BITS);

   typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

   state_t        state;
   logic          rxd_meta;
   logic          rxd_sync;
   logic          rxd_last;
   logic [SW-1:0] smp;
   logic [BW-1:0] bit_cnt;
   byte_t         shreg;
   logic          fall;
   logic          sample;

   ////////////////////////////////////////////////////////////////////////////
   // Synchronizer and edge detect
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge RST_N) begin
      if (!RST_N) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_last <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_last <= rxd_sync;
      end
   end

   assign fall = (state == S_IDLE) && rxd_last && !rxd_sync;

   // Sample near mid-bit, half a bit after the phase restart
   assign sample = tick && (smp == SW'(SAMPLES_PER_BIT / 2 - 1));

   always_ff @(posedge clk or negedge RST_N) begin
      if (!RST_N) begin
         state   <= S_IDLE;
         smp     <= '0;
         bit_cnt <= '0;
         valid   <= 1'b0;
      end else begin
         valid <= 1'b0;
         if (fall) begin
            smp <= '0;
         end else if (tick) begin
            smp <= (smp == SW'(SAMPLES_PER_BIT - 1)) ? '0 : smp + 1'b1;
         end
         case (state)
            S_IDLE: begin
               if (fall) begin
                  state <= S_START;
               end
            end
            S_START: begin
               if (sample) begin
                  // Glitch, not a start bit
                  state   <= rxd_sync ? S_IDLE : S_DATA;
                  bit_cnt <= '0;
               end
            end
            S_DATA: begin
               if (sample) begin
                  if (bit_cnt == BW'(DATA_BITS - 1)) begin
                     state <= S_STOP;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            S_STOP: begin
               if (sample) begin
                  state <= S_IDLE;
                  // Framing error drops the byte
                  valid <= rxd_sync;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (sample && state == S_DATA) begin
         shreg <= {rxd_sync, shreg[DATA_BITS-1:1]};
      end
   end

   assign data = shreg;

endmodule

`default_nettype wire

// File: source/uart_axil_top.sv
`default_nettype none

module uart_axil_top
   import axil_pkg::*;
   import uart_pkg::*;
#(
   parameter int CLKS_PER_TICK = 4,
   parameter int FIFO_AW       = 4
)
(
   input  wire logic  clk,
   input  wire logic  RST_N,
   input  wire addr_t awaddr,
   input  wire logic  awvalid,
   output logic       awready,
   input  wire data_t wdata,
   input  wire logic  wvalid,
   output logic       wready,
   output logic       bvalid,
   input  wire logic  bready,
   output resp_t      bresp,
   input  wire addr_t araddr,
   input  wire logic  arvalid,
   output logic       arready,
   output logic       rvalid,
   input  wire logic  rready,
   output data_t      rdata,
   output resp_t      rresp,
   output logic       interrupt,
   input  wire logic  rxd,
   output logic       txd
);

   addr_t reg_addr;
   logic  reg_wr;
   data_t reg_wdata;
   logic  reg_rd;
   data_t reg_rdata;

   logic  tx_push;
   byte_t tx_byte;
   logic  tx_full;
   logic  tx_fifo_empty;
   logic  tx_pop;
   byte_t tx_front;
   logic  tx_busy;

   logic  rx_valid;
   byte_t rx_byte;
   logic  rx_pop;
   byte_t rx_front;
   logic  rx_empty;

   logic  tick;

   ////////////////////////////////////////////////////////////////////////////
   // Bus and register block
   ////////////////////////////////////////////////////////////////////////////
   axil_slave u_axil_slave (
      .clk       (clk),
      .RST_N     (RST_N),
      .awaddr    (awaddr),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wvalid    (wvalid),
      .wready    (wready),
      .bvalid    (bvalid),
      .bready    (bready),
      .bresp     (bresp),
      .araddr    (araddr),
      .arvalid   (arvalid),
      .arready   (arready),
      .rvalid    (rvalid),
      .rready    (rready),
      .rdata     (rdata),
      .rresp     (rresp),
      .reg_addr  (reg_addr),
      .reg_wr    (reg_wr),
      .reg_wdata (reg_wdata),
      .reg_rd    (reg_rd),
      .reg_rdata (reg_rdata)
   );

   uart_ctl u_uart_ctl (
      .clk           (clk),
      .RST_N         (RST_N),
      .reg_addr      (reg_addr),
      .reg_wr        (reg_wr),
      .reg_wdata     (reg_wdata),
      .reg_rd        (reg_rd),
      .reg_rdata     (reg_rdata),
      .tx_push       (tx_push),
      .tx_byte       (tx_byte),
      .tx_full       (tx_full),
      .tx_fifo_empty (tx_fifo_empty),
      .tx_busy       (tx_busy),
      .rx_pop        (rx_pop),
      .rx_front      (rx_front),
      .rx_empty      (rx_empty),
      .interrupt     (interrupt)
   );

   ////////////////////////////////////////////////////////////////////////////
   // FIFOs and serial side
   ////////////////////////////////////////////////////////////////////////////
   byte_fifo #(.FIFO_AW(FIFO_AW)) u_tx_fifo (
      .clk       (clk),
      .RST_N     (RST_N),
      .push      (tx_push),
      .push_data (tx_byte),
      .full      (tx_full),
      .pop       (tx_pop),
      .pop_data  (tx_front),
      .empty     (tx_fifo_empty)
   );

   // Overflow handled inside the FIFO
   byte_fifo #(.FIFO_AW(FIFO_AW)) u_rx_fifo (
      .clk       (clk),
      .RST_N     (RST_N),
      .push      (rx_valid),
      .push_data (rx_byte),
      .full      (),
      .pop       (rx_pop),
      .pop_data  (rx_front),
      .empty     (rx_empty)
   );

   baud_tick #(.CLKS_PER_TICK(CLKS_PER_TICK)) u_baud_tick (
      .clk   (clk),
      .RST_N (RST_N),
      .tick  (tick)
   );

   uart_tx u_uart_tx (
      .clk        (clk),
      .RST_N      (RST_N),
      .tick       (tick),
      .fifo_empty (tx_fifo_empty),
      .data       (tx_front),
      .pop        (tx_pop),
      .busy       (tx_busy),
      .txd        (txd)
   );

   uart_rx u_uart_rx (
      .clk   (clk),
      .RST_N (RST_N),
      .tick  (tick),
      .rxd   (rxd),
      .valid (rx_valid),
      .data  (rx_byte)
   );

endmodule

`default_nettype wire

// File: testbench/tb_uart_axil_asserts.sv
`default_nettype none

module tb_uart_axil_asserts
   import axil_pkg::*;
(
   input wire logic  clk,
   input wire logic  RST_N,
   input wire logic  bvalid,
   input wire logic  bready,
   input wire logic  rvalid,
   input wire logic  rready,
   input wire data_t rdata,
   input wire logic  txd,
   input wire logic  tx_busy
);

   timeunit 1ns;
   timeprecision 1ps;

   // Failure count, polled by the testbench
   int errors = 0;

   bvalid_hold: assert property (@(posedge clk) disable iff (!RST_N)
      bvalid && !bready |=> bvalid)
      else begin
         errors++;
         $error("bvalid dropped before bready");
      end

   rvalid_hold: assert property (@(posedge clk) disable iff (!RST_N)
      rvalid && !rready |=> rvalid)
      else begin
         errors++;
         $error("rvalid dropped before rready");
      end

   rdata_stable: assert property (@(posedge clk) disable iff (!RST_N)
      rvalid && !rready |=> $stable(rdata))
      else begin
         errors++;
         $error("rdata changed while rvalid waited");
      end

   // Line idles high between frames
   txd_idle: assert property (@(posedge clk) disable iff (!RST_N)
      !tx_busy |-> txd)
      else begin
         errors++;
         $error("txd low while transmitter idle");
      end

endmodule

bind uart_axil_top tb_uart_axil_asserts u_asserts (
   .clk     (clk),
   .RST_N   (RST_N),
   .bvalid  (bvalid),
   .bready  (bready),
   .rvalid  (rvalid),
   .rready  (rready),
   .rdata   (rdata),
   .txd     (txd),
   .tx_busy (tx_busy)
);

`default_nettype wire

// File: testbench/tb_uart_axil.sv
`default_nettype none

module tb_uart_axil
   import axil_pkg::*;
   import uart_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLKS_PER_TICK  = 4;
   localparam int FIFO_AW        = 4;
   localparam int DEPTH          = 2 ** FIFO_AW;
   localparam int BIT_CLKS       = CLKS_PER_TICK * SAMPLES_PER_BIT;
   localparam int N_TX           = 6;
   localparam int N_RX           = 6;
   localparam int TIMEOUT_CYCLES = (N_TX + N_RX) * 10 * BIT_CLKS + 2000;

   logic  clk;
   logic  RST_N;
   addr_t awaddr;
   logic  awvalid;
   logic  awready;
   data_t wdata;
   logic  wvalid;
   logic  wready;
   logic  bvalid;
   logic  bready;
   resp_t bresp;
   addr_t araddr;
   logic  arvalid;
   logic  arready;
   logic  rvalid;
   logic  rready;
   data_t rdata;
   resp_t rresp;
   logic  interrupt;
   logic  rxd;
   logic  txd;

   // Pending comparisons
   string cmp_name[$];
   data_t cmp_exp[$];
   data_t cmp_got[$];
   byte_t tx_expected[$];
   byte_t tx_seen[$];
   byte_t rx_model[$];
   int    tx_written;
   int    frames_done;
   int    cycles;
   bit    ie_rx_m;
   bit    ie_tx_m;

   uart_axil_top #(
      .CLKS_PER_TICK (CLKS_PER_TICK),
      .FIFO_AW       (FIFO_AW)
   ) UUT (
      .clk       (clk),
      .RST_N     (RST_N),
      .awaddr    (awaddr),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wvalid    (wvalid),
      .wready    (wready),
      .bvalid    (bvalid),
      .bready    (bready),
      .bresp     (bresp),
      .araddr    (araddr),
      .arvalid   (arvalid),
      .arready   (arready),
      .rvalid    (rvalid),
      .rready    (rready),
      .rdata     (rdata),
      .rresp     (rresp),
      .interrupt (interrupt),
      .rxd       (rxd),
      .txd       (txd)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////
   function automatic data_t expected_status(input int rx_level, input int tx_level);
      data_t s;
      s = '0;
      s[ST_RX_EMPTY] = (rx_level == 0);
      // One byte sits in the transmitter once it starts
      s[ST_TX_FULL]  = (tx_level > DEPTH);
      s[ST_TX_EMPTY] = (tx_level == 0);
      return s;
   endfunction

   function automatic logic expected_irq(input bit en_rx, input bit en_tx,
                                         input int rx_level, input int tx_level);
      return (en_tx && (tx_level > DEPTH)) || (en_rx && (rx_level == 0));
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input data_t exp, input data_t got);
      $display("Mismatch at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, got);
      stop_with_failure("Value comparison failed");
   endtask

   task automatic queue_compare(input string name, input data_t exp, input data_t got);
      cmp_name.push_back(name);
      cmp_exp.push_back(exp);
      cmp_got.push_back(got);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus tasks
   ////////////////////////////////////////////////////////////////////////////
   task automatic write_reg(input addr_t a, input data_t d);
      int delay;
      delay = $urandom_range(0, 3);
      @(posedge clk);
      awaddr  <= a;
      awvalid <= 1'b1;
      do @(posedge clk); while (!awready);
      awvalid <= 1'b0;
      wdata   <= d;
      wvalid  <= 1'b1;
      do @(posedge clk); while (!wready);
      wvalid <= 1'b0;
      repeat (delay) @(posedge clk);
      bready <= 1'b1;
      do @(posedge clk); while (!bvalid);
      bready <= 1'b0;
      queue_compare("bresp", data_t'(RESP_OKAY), data_t'(bresp));
   endtask

   task automatic read_reg(input addr_t a, output data_t d);
      int delay;
      delay = $urandom_range(0, 4);
      @(posedge clk);
      araddr  <= a;
      arvalid <= 1'b1;
      do @(posedge clk); while (!arready);
      arvalid <= 1'b0;
      repeat (delay) @(posedge clk);
      rready <= 1'b1;
      do @(posedge clk); while (!rvalid);
      d = rdata;
      rready <= 1'b0;
      queue_compare("rresp", data_t'(RESP_OKAY), data_t'(rresp));
   endtask

   task automatic expect_read(input addr_t a, input data_t exp, input string name);
      data_t got;
      read_reg(a, got);
      queue_compare(name, exp, got);
   endtask

   task automatic set_intena(input bit en_rx, input bit en_tx);
      data_t v;
      v = '0;
      v[IE_RX] = en_rx;
      v[IE_TX] = en_tx;
      // Upper bits are not stored
      write_reg(A_INTENA, v | ($urandom() & 32'hFFFF_FFFC));
      ie_rx_m = en_rx;
      ie_tx_m = en_tx;
      expect_read(A_INTENA, v, "INTENA");
      queue_compare("interrupt",
                    data_t'(expected_irq(en_rx, en_tx, rx_model.size(),
                                         tx_written - frames_done)),
                    data_t'(interrupt));
   endtask

   // 8N1 frame on rxd, LSB first
   task automatic send_frame(input byte_t b);
      int i;
      @(posedge clk);
      rxd <= 1'b0;
      repeat (BIT_CLKS) @(posedge clk);
      for (i = 0; i < DATA_BITS; i++) begin
         rxd <= b[i];
         repeat (BIT_CLKS) @(posedge clk);
      end
      rxd <= 1'b1;
      repeat (BIT_CLKS) @(posedge clk);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Clock, watchdog, serial monitor, compare
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin : watchdog
      cycles = 0;
      forever begin
         @(posedge clk);
         cycles++;
         assert (cycles <= TIMEOUT_CYCLES)
            else stop_with_failure("Timeout: the run did not finish within the cycle limit");
      end
   end

   initial begin : txd_monitor
      byte_t b;
      int    i;
      frames_done = 0;
      wait (RST_N === 1'b1);
      forever begin
         @(negedge txd);
         repeat (BIT_CLKS / 2) @(posedge clk);
         assert (txd === 1'b0)
            else stop_with_failure("Start bit on txd did not stay low to mid-bit");
         for (i = 0; i < DATA_BITS; i++) begin
            repeat (BIT_CLKS) @(posedge clk);
            b[i] = txd;
         end
         repeat (BIT_CLKS) @(posedge clk);
         assert (txd === 1'b1)
            else stop_with_failure("Stop bit on txd was not high");
         tx_seen.push_back(b);
         // Rest of the stop bit
         repeat (BIT_CLKS / 2) @(posedge clk);
         frames_done++;
      end
   end

   initial begin : compare
      string name;
      data_t exp;
      data_t got;
      byte_t eb;
      byte_t gb;
      forever begin
         @(posedge clk);
         assert (UUT.u_asserts.errors == 0)
            else stop_with_failure("A bound protocol assertion failed");
         while (cmp_got.size() > 0) begin
            name = cmp_name.pop_front();
            exp  = cmp_exp.pop_front();
            got  = cmp_got.pop_front();
            assert (got === exp) else report_mismatch(name, exp, got);
         end
         while (tx_seen.size() > 0) begin
            gb = tx_seen.pop_front();
            assert (tx_expected.size() > 0)
               else stop_with_failure("A frame appeared on txd with no byte written");
            eb = tx_expected.pop_front();
            assert (gb === eb) else report_mismatch("txd frame", data_t'(eb), data_t'(gb));
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin : main
      byte_t b;
      int    gap;
      int    i;
      void'($urandom(32'h3e77));
      RST_N   = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      rxd     = 1'b1;
      tx_written = 0;
      ie_rx_m = 1'b0;
      ie_tx_m = 1'b0;
      repeat (16) @(posedge clk);
      RST_N <= 1'b1;
      @(posedge clk);

      // Reset state
      queue_compare("txd", 32'd1, data_t'(txd));
      queue_compare("interrupt", 32'd0, data_t'(interrupt));
      // Idle bus accepts addresses only
      queue_compare("awready", 32'd1, data_t'(awready));
      queue_compare("arready", 32'd1, data_t'(arready));
      queue_compare("wready", 32'd0, data_t'(wready));
      queue_compare("bvalid", 32'd0, data_t'(bvalid));
      queue_compare("rvalid", 32'd0, data_t'(rvalid));
      expect_read(A_STATUS, expected_status(0, 0), "STATUS");

      // Interrupt enables
      set_intena(1'b1, 1'b0);
      set_intena(1'b1, 1'b1);
      set_intena(1'b0, 1'b1);
      set_intena(1'b0, 1'b0);

      // Transmit path
      for (i = 0; i < N_TX; i++) begin
         b = byte_t'($urandom_range(0, 255));
         tx_expected.push_back(b);
         write_reg(A_TXD, data_t'(b));
         tx_written++;
      end
      expect_read(A_STATUS, expected_status(0, tx_written - frames_done), "STATUS");
      wait (frames_done == N_TX);
      expect_read(A_STATUS, expected_status(0, 0), "STATUS");

      // Receive path
      set_intena(1'b1, 1'b0);
      for (i = 0; i < N_RX; i++) begin
         b   = byte_t'($urandom_range(0, 255));
         gap = $urandom_range(0, 15);
         send_frame(b);
         rx_model.push_back(b);
         repeat (gap) @(posedge clk);
      end
      repeat (BIT_CLKS) @(posedge clk);
      queue_compare("interrupt",
                    data_t'(expected_irq(ie_rx_m, ie_tx_m, rx_model.size(), 0)),
                    data_t'(interrupt));
      // Each RXD read removes exactly one byte
      while (rx_model.size() > 0) begin
         b = rx_model.pop_front();
         expect_read(A_RXD, data_t'(b), "RXD");
         expect_read(A_STATUS, expected_status(rx_model.size(), 0), "STATUS");
      end
      expect_read(A_RXD, 32'd0, "RXD");
      queue_compare("interrupt",
                    data_t'(expected_irq(ie_rx_m, ie_tx_m, 0, 0)),
                    data_t'(interrupt));

      repeat (4) @(posedge clk);
      assert (cmp_got.size() == 0 && tx_seen.size() == 0 && tx_expected.size() == 0)
         else stop_with_failure("Some reads or frames were never compared");
      if (UUT.u_asserts.errors == 0) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         stop_with_failure("Bound protocol assertions reported errors");
      end
   end

endmodule

`default_nettype wire

// File: uart_axil.f
source/axil_pkg.sv
source/uart_pkg.sv
source/axil_slave.sv
source/uart_ctl.sv
source/byte_fifo.sv
source/baud_tick.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_axil_top.sv
testbench/tb_uart_axil_asserts.sv
testbench/tb_uart_axil.sv
